// ==== logic/fp_mult_cfg.svh ====
// Build-time constants of the Fp multiplier, included by the packages, the RTL and the testbench
`ifndef FP_MULT_CFG_SVH
`define FP_MULT_CFG_SVH

// Prime modulus, 2^32 - 5
`define FP_P 32'hFFFF_FFFB

// Width of one field element
`define FP_DAT_BITS 32

// Karatsuba recursion depth, each level adds 3 cycles
`define FP_KARATSUBA_LVL 2

// Width of the user tag
`define FP_CTL_BITS 16

// Reduction needs one spare bit, then round up to a multiple of 2*level
`define FP_MLT_BITS ((`FP_DAT_BITS + 1) + (2 * `FP_KARATSUBA_LVL - \
  (`FP_DAT_BITS + 1) % (2 * `FP_KARATSUBA_LVL)))

// Barrett exponent and floor(4^k / P)
`define FP_BARRETT_K `FP_DAT_BITS
`define FP_BARRETT_MU 36'h1_0000_0005

`endif

// ==== logic/fp_types_pkg.sv ====
// Vector types with a meaning of their own, imported by the RTL and the testbench
`include "fp_mult_cfg.svh"

package fp_types_pkg;

  // One element of Fp
  typedef logic [`FP_DAT_BITS-1:0] fp_dat_t;

  // Operand as seen by a multiplier, zero-padded
  typedef logic [`FP_MLT_BITS-1:0] mlt_dat_t;

  // Full double-width product
  typedef logic [2*`FP_MLT_BITS-1:0] mlt_prod_t;

  // User tag carried from request to result
  typedef logic [`FP_CTL_BITS-1:0] ctl_t;

  // Multiplier side data
  // Upper part holds a saved product word, low part the user tag
  typedef logic [`FP_CTL_BITS+2*`FP_MLT_BITS-1:0] mult_ctl_t;

endpackage

// ==== logic/fp_stream_pkg.sv ====
// Payload structs of the valid/ready streams, imported by the RTL and the testbench
`include "fp_mult_cfg.svh"

package fp_stream_pkg;

  // Request beat at the top level
  typedef struct packed {
    fp_types_pkg::fp_dat_t a;
    fp_types_pkg::fp_dat_t b;
    fp_types_pkg::ctl_t    ctl;
  } fp_mul_req_t;

  // Result beat at the top level, result is below P
  typedef struct packed {
    fp_types_pkg::fp_dat_t result;
    fp_types_pkg::ctl_t    ctl;
  } fp_mul_rsp_t;

  // Operand pair into a multiplier
  typedef struct packed {
    fp_types_pkg::mlt_dat_t  dat_a;
    fp_types_pkg::mlt_dat_t  dat_b;
    fp_types_pkg::mult_ctl_t ctl;
  } mult_req_t;

  // Product out of a multiplier, ctl returned untouched
  typedef struct packed {
    fp_types_pkg::mlt_prod_t dat;
    fp_types_pkg::mult_ctl_t ctl;
  } mult_rsp_t;

endpackage

// ==== logic/karatsuba_ofman_mult.sv ====
// Recursive pipelined Karatsuba-Ofman multiplier that the Fp top level instantiates three times
`timescale 1ns/1ps
`include "fp_mult_cfg.svh"

module karatsuba_ofman_mult #(
  parameter int BITS  = `FP_MLT_BITS,
  parameter int LEVEL = `FP_KARATSUBA_LVL
) (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  fp_stream_pkg::mult_req_t i_req,
  input  logic                     i_val,
  output logic                     o_rdy,
  output fp_stream_pkg::mult_rsp_t o_rsp,
  output logic                     o_val,
  input  logic                     i_rdy
);

  import fp_types_pkg::*;
  import fp_stream_pkg::*;

  // One enable for all stages of this level
  logic en;

  assign en    = i_rdy | ~o_val;
  assign o_rdy = en;

  if (LEVEL > 0) begin : g_split
    localparam int HALF      = BITS / 2;
    // Middle product plus carry terms needs two extra bits
    localparam int CORR_BITS = BITS + 2;
    localparam int PROD_BITS = 2 * BITS;

    logic [HALF-1:0]      a_lo;
    logic [HALF-1:0]      a_hi;
    logic [HALF-1:0]      b_lo;
    logic [HALF-1:0]      b_hi;
    logic [HALF:0]        sum_a;
    logic [HALF:0]        sum_b;
    logic [CORR_BITS-1:0] corr;
    mult_req_t            lo_nxt;
    mult_req_t            hi_nxt;
    mult_req_t            mid_nxt;
    // Stage A holds the operands for the three sub-products
    mult_req_t            lo_req;
    mult_req_t            hi_req;
    mult_req_t            mid_req;
    logic                 a_val;
    logic                 sub_in_val;
    mult_rsp_t            lo_rsp;
    mult_rsp_t            hi_rsp;
    mult_rsp_t            mid_rsp;
    logic [2:0]           sub_val;
    logic [CORR_BITS-1:0] z1;
    // Stage B holds the partial products
    logic [BITS-1:0]      z0_q;
    logic [BITS-1:0]      z2_q;
    logic [CORR_BITS-1:0] mid_q;
    mult_ctl_t            b_ctl;
    logic                 b_val;
    logic [PROD_BITS-1:0] prod;

    always_comb begin
      a_lo  = i_req.dat_a[HALF-1:0];
      a_hi  = i_req.dat_a[BITS-1:HALF];
      b_lo  = i_req.dat_b[HALF-1:0];
      b_hi  = i_req.dat_b[BITS-1:HALF];
      sum_a = a_lo + a_hi;
      sum_b = b_lo + b_hi;
      // Sub-multiplier only sees the low HALF bits of each sum
      // Carry-outs are folded back in here
      corr = '0;
      if (sum_a[HALF]) begin
        corr = corr + (CORR_BITS'(sum_b[HALF-1:0]) << HALF);
      end
      if (sum_b[HALF]) begin
        corr = corr + (CORR_BITS'(sum_a[HALF-1:0]) << HALF);
      end
      if (sum_a[HALF] && sum_b[HALF]) begin
        corr = corr + (CORR_BITS'(1) << BITS);
      end
      lo_nxt.dat_a  = mlt_dat_t'(a_lo);
      lo_nxt.dat_b  = mlt_dat_t'(b_lo);
      lo_nxt.ctl    = i_req.ctl;
      hi_nxt.dat_a  = mlt_dat_t'(a_hi);
      hi_nxt.dat_b  = mlt_dat_t'(b_hi);
      hi_nxt.ctl    = '0;
      mid_nxt.dat_a = mlt_dat_t'(sum_a[HALF-1:0]);
      mid_nxt.dat_b = mlt_dat_t'(sum_b[HALF-1:0]);
      // Correction rides along with the middle product
      mid_nxt.ctl   = mult_ctl_t'(corr);
    end

    // Sub-multipliers only take a beat while this level advances
    assign sub_in_val = a_val & en;

    karatsuba_ofman_mult #(.BITS(HALF), .LEVEL(LEVEL - 1)) mult_lo (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_req    (lo_req),
      .i_val    (sub_in_val),
      .o_rdy    (),
      .o_rsp    (lo_rsp),
      .o_val    (sub_val[0]),
      .i_rdy    (en)
    );

    karatsuba_ofman_mult #(.BITS(HALF), .LEVEL(LEVEL - 1)) mult_hi (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_req    (hi_req),
      .i_val    (sub_in_val),
      .o_rdy    (),
      .o_rsp    (hi_rsp),
      .o_val    (sub_val[1]),
      .i_rdy    (en)
    );

    karatsuba_ofman_mult #(.BITS(HALF), .LEVEL(LEVEL - 1)) mult_mid (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_req    (mid_req),
      .i_val    (sub_in_val),
      .o_rdy    (),
      .o_rsp    (mid_rsp),
      .o_val    (sub_val[2]),
      .i_rdy    (en)
    );

    // z1 - z2 - z0 gives the cross terms a_lo*b_hi + a_hi*b_lo
    assign z1   = CORR_BITS'(mid_rsp.dat[BITS-1:0]) + mid_rsp.ctl[CORR_BITS-1:0];
    // z2 and z0 do not overlap, so they simply concatenate
    assign prod = {z2_q, z0_q} + (PROD_BITS'(mid_q) << HALF);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        a_val <= 1'b0;
        b_val <= 1'b0;
        o_val <= 1'b0;
      end else if (en) begin
        a_val <= i_val;
        b_val <= &sub_val;
        o_val <= b_val;
      end
    end

    always_ff @(posedge i_clk) begin
      if (en) begin
        lo_req    <= lo_nxt;
        hi_req    <= hi_nxt;
        mid_req   <= mid_nxt;
        z0_q      <= lo_rsp.dat[BITS-1:0];
        z2_q      <= hi_rsp.dat[BITS-1:0];
        mid_q     <= z1 - CORR_BITS'(hi_rsp.dat[BITS-1:0]) - CORR_BITS'(lo_rsp.dat[BITS-1:0]);
        b_ctl     <= lo_rsp.ctl;
        o_rsp.dat <= mlt_prod_t'(prod);
        o_rsp.ctl <= b_ctl;
      end
    end

  end else begin : g_base
    logic [2*BITS-1:0] prod;

    // Leaf product maps to a DSP block
    assign prod = i_req.dat_a[BITS-1:0] * i_req.dat_b[BITS-1:0];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        o_val <= 1'b0;
      end else if (en) begin
        o_val <= i_val;
      end
    end

    always_ff @(posedge i_clk) begin
      if (en) begin
        o_rsp.dat <= mlt_prod_t'(prod);
        o_rsp.ctl <= i_req.ctl;
      end
    end
  end

  // Stalled output beat stays put until taken
  a_out_hold : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_val && !i_rdy) |=> (o_val && $stable(o_rsp)))
    else $error("output changed while stalled at level %0d", LEVEL);

endmodule

// ==== logic/barret_mod_pipe.sv ====
// Barrett reduction of a double-width product mod P, using two external multipliers
`timescale 1ns/1ps
`include "fp_mult_cfg.svh"

module barret_mod_pipe (
  input  logic                       i_clk,
  input  logic                       i_arst_n,
  // Unreduced product x = a*b
  input  fp_stream_pkg::mult_rsp_t   i_prod,
  input  logic                       i_val,
  output logic                       o_rdy,
  // Reduced result
  output fp_stream_pkg::fp_mul_rsp_t o_rsp,
  output logic                       o_val,
  input  logic                       i_rdy,
  // q1 * mu
  output fp_stream_pkg::mult_req_t   o_mult_0,
  output logic                       o_mult_0_val,
  input  logic                       i_mult_0_rdy,
  input  fp_stream_pkg::mult_rsp_t   i_mult_0,
  input  logic                       i_mult_0_val,
  output logic                       o_mult_0_rdy,
  // q * P
  output fp_stream_pkg::mult_req_t   o_mult_1,
  output logic                       o_mult_1_val,
  input  logic                       i_mult_1_rdy,
  input  fp_stream_pkg::mult_rsp_t   i_mult_1,
  input  logic                       i_mult_1_val,
  output logic                       o_mult_1_rdy
);

  import fp_types_pkg::*;
  import fp_stream_pkg::*;

  localparam int       K        = `FP_BARRETT_K;
  localparam int       CTL_BITS = `FP_CTL_BITS;
  localparam int       MLT_BITS = `FP_MLT_BITS;
  localparam mlt_dat_t P_M      = mlt_dat_t'(`FP_P);
  localparam mlt_dat_t MU       = `FP_BARRETT_MU;

  logic      s1_en;
  logic      s2_en;
  logic      s3_en;
  logic      s4_en;
  mlt_prod_t x_saved;
  mlt_prod_t diff;
  mlt_dat_t  r0;
  mlt_dat_t  r1;
  mlt_dat_t  r2;
  // Tail stage registers
  mlt_dat_t  r1_q;
  ctl_t      tag_q;
  logic      r_val;

  // Each slice loads when empty or when its beat moves on
  assign s1_en        = ~o_mult_0_val | i_mult_0_rdy;
  assign s2_en        = ~o_mult_1_val | i_mult_1_rdy;
  assign s4_en        = ~o_val | i_rdy;
  assign s3_en        = ~r_val | s4_en;
  assign o_rdy        = s1_en;
  assign o_mult_0_rdy = s2_en;
  assign o_mult_1_rdy = s3_en;

  // x comes back in the side data of the second multiplier
  assign x_saved = i_mult_1.ctl[CTL_BITS +: 2*MLT_BITS];
  // True remainder is below 3P, so the low bits are enough
  assign diff    = x_saved - i_mult_1.dat;
  assign r0      = diff[MLT_BITS-1:0];
  assign r1      = (r0 >= P_M) ? r0 - P_M : r0;
  assign r2      = (r1_q >= P_M) ? r1_q - P_M : r1_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_mult_0_val <= 1'b0;
      o_mult_1_val <= 1'b0;
      r_val        <= 1'b0;
      o_val        <= 1'b0;
    end else begin
      if (s1_en) begin
        o_mult_0_val <= i_val;
      end
      if (s2_en) begin
        o_mult_1_val <= i_mult_0_val;
      end
      if (s3_en) begin
        r_val <= i_mult_1_val;
      end
      if (s4_en) begin
        o_val <= r_val;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    // q1 = x >> (k-1), x saved next to the tag
    if (s1_en) begin
      o_mult_0.dat_a <= mlt_dat_t'(i_prod.dat >> (K - 1));
      o_mult_0.dat_b <= MU;
      o_mult_0.ctl   <= {i_prod.dat, i_prod.ctl[CTL_BITS-1:0]};
    end
    // q = (q1 * mu) >> (k+1)
    if (s2_en) begin
      o_mult_1.dat_a <= mlt_dat_t'(i_mult_0.dat >> (K + 1));
      o_mult_1.dat_b <= P_M;
      o_mult_1.ctl   <= i_mult_0.ctl;
    end
    // First correction
    if (s3_en) begin
      r1_q  <= r1;
      tag_q <= i_mult_1.ctl[CTL_BITS-1:0];
    end
    // Second correction
    if (s4_en) begin
      o_rsp.result <= fp_dat_t'(r2);
      o_rsp.ctl    <= tag_q;
    end
  end

  // Barrett estimate is off by at most two multiples of P
  a_result_reduced : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_val |-> (o_rsp.result < `FP_P))
    else $error("result %0h not below P", o_rsp.result);

endmodule

// ==== logic/ec_fp_mult_mod.sv ====
// Top level Fp multiplier, a*b mod P with tags kept in order, latency 25 cycles
`timescale 1ns/1ps
`include "fp_mult_cfg.svh"

module ec_fp_mult_mod (
  input  logic                       i_clk,
  input  logic                       i_arst_n,
  input  fp_stream_pkg::fp_mul_req_t i_req,
  input  logic                       i_req_val,
  output logic                       o_req_rdy,
  output fp_stream_pkg::fp_mul_rsp_t o_rsp,
  output logic                       o_rsp_val,
  input  logic                       i_rsp_rdy
);

  import fp_types_pkg::*;
  import fp_stream_pkg::*;

  // Multiplier 0, a*b
  mult_req_t k0_req;
  mult_rsp_t k0_rsp;
  logic      k0_rsp_val;
  logic      k0_rsp_rdy;
  // Multiplier 1, Barrett estimate
  mult_req_t k1_req;
  logic      k1_req_val;
  logic      k1_req_rdy;
  mult_rsp_t k1_rsp;
  logic      k1_rsp_val;
  logic      k1_rsp_rdy;
  // Multiplier 2, estimate times P
  mult_req_t k2_req;
  logic      k2_req_val;
  logic      k2_req_rdy;
  mult_rsp_t k2_rsp;
  logic      k2_rsp_val;
  logic      k2_rsp_rdy;

  // Zero-pad operands, no saved product yet
  always_comb begin
    k0_req.dat_a = mlt_dat_t'(i_req.a);
    k0_req.dat_b = mlt_dat_t'(i_req.b);
    k0_req.ctl   = {mlt_prod_t'(0), i_req.ctl};
  end

  karatsuba_ofman_mult #(.BITS(`FP_MLT_BITS), .LEVEL(`FP_KARATSUBA_LVL)) karatsuba_ofman_mult_0 (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (k0_req),
    .i_val    (i_req_val),
    .o_rdy    (o_req_rdy),
    .o_rsp    (k0_rsp),
    .o_val    (k0_rsp_val),
    .i_rdy    (k0_rsp_rdy)
  );

  karatsuba_ofman_mult #(.BITS(`FP_MLT_BITS), .LEVEL(`FP_KARATSUBA_LVL)) karatsuba_ofman_mult_1 (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (k1_req),
    .i_val    (k1_req_val),
    .o_rdy    (k1_req_rdy),
    .o_rsp    (k1_rsp),
    .o_val    (k1_rsp_val),
    .i_rdy    (k1_rsp_rdy)
  );

  karatsuba_ofman_mult #(.BITS(`FP_MLT_BITS), .LEVEL(`FP_KARATSUBA_LVL)) karatsuba_ofman_mult_2 (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (k2_req),
    .i_val    (k2_req_val),
    .o_rdy    (k2_req_rdy),
    .o_rsp    (k2_rsp),
    .o_val    (k2_rsp_val),
    .i_rdy    (k2_rsp_rdy)
  );

  barret_mod_pipe barret_mod_pipe_0 (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_prod       (k0_rsp),
    .i_val        (k0_rsp_val),
    .o_rdy        (k0_rsp_rdy),
    .o_rsp        (o_rsp),
    .o_val        (o_rsp_val),
    .i_rdy        (i_rsp_rdy),
    .o_mult_0     (k1_req),
    .o_mult_0_val (k1_req_val),
    .i_mult_0_rdy (k1_req_rdy),
    .i_mult_0     (k1_rsp),
    .i_mult_0_val (k1_rsp_val),
    .o_mult_0_rdy (k1_rsp_rdy),
    .o_mult_1     (k2_req),
    .o_mult_1_val (k2_req_val),
    .i_mult_1_rdy (k2_req_rdy),
    .i_mult_1     (k2_rsp),
    .i_mult_1_val (k2_rsp_val),
    .o_mult_1_rdy (k2_rsp_rdy)
  );

endmodule

// ==== testbench/tb_ec_fp_mult_mod.sv ====
// Self-checking testbench for the Fp multiplier that runs as the top module of the file list
`timescale 1ns/1ps
`include "fp_mult_cfg.svh"

module tb_ec_fp_mult_mod;

  import fp_types_pkg::*;
  import fp_stream_pkg::*;

  localparam int RST_CYCLES  = 16;
  localparam int LATENCY     = 25;
  localparam int N_EDGE      = 6;
  localparam int N_RAND      = 200;
  localparam int N_STALL     = 150;
  localparam int N_SUSTAIN   = 100;
  localparam int NUM_REQ     = N_EDGE + N_RAND + 1 + N_STALL + N_SUSTAIN;
  localparam int DRAIN_LIMIT = 8 * LATENCY;
  // Reset plus up to three cycles per request under random stalls and one drain per test
  localparam int MAX_CYCLES  = RST_CYCLES + 3 * NUM_REQ + 5 * DRAIN_LIMIT;
  localparam fp_dat_t PM1    = `FP_P - 1;

  logic        i_clk;
  logic        i_arst_n;
  fp_mul_req_t i_req;
  logic        i_req_val;
  logic        o_req_rdy;
  fp_mul_rsp_t o_rsp;
  logic        o_rsp_val;
  logic        i_rsp_rdy;

  // Expected results and their issue cycles in request order
  fp_mul_rsp_t exp_q[$];
  int          issue_q[$];
  int          cycle;
  int          in_count;
  int          checked;
  int          errors;
  int          test_errors;
  int          last_latency;
  int          rdy_drops;
  logic [31:0] lfsr;
  logic        rand_rdy;
  ctl_t        next_tag;

  ec_fp_mult_mod ec_fp_mult_mod_inst (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_req     (i_req),
    .i_req_val (i_req_val),
    .o_req_rdy (o_req_rdy),
    .o_rsp     (o_rsp),
    .o_rsp_val (o_rsp_val),
    .i_rsp_rdy (i_rsp_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // (a*b) mod P in plain 64-bit arithmetic
  function automatic fp_dat_t ref_mod_mult(input fp_dat_t a, input fp_dat_t b);
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    return fp_dat_t'(prod % {32'd0, `FP_P});
  endfunction

  // Galois LFSR shifting right with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Redraw until below P
  function automatic fp_dat_t rand_operand();
    fp_dat_t v;
    v = rand_bits(32);
    while (v >= `FP_P) begin
      v = rand_bits(32);
    end
    return v;
  endfunction

  // All stimulus moves on falling edges and ready toggles here in stall mode
  task automatic wait_negedge();
    logic [31:0] bit_draw;
    @(negedge i_clk);
    if (rand_rdy) begin
      bit_draw  = rand_bits(1);
      i_rsp_rdy = bit_draw[0];
    end
  endtask

  // Holds the beat until the monitor sees it transfer
  task automatic send_req(input fp_dat_t a, input fp_dat_t b);
    int seen;
    seen      = in_count;
    i_req.a   = a;
    i_req.b   = b;
    i_req.ctl = next_tag;
    i_req_val = 1'b1;
    next_tag  = next_tag + ctl_t'(1);
    do begin
      wait_negedge();
    end while (in_count == seen);
  endtask

  task automatic drain();
    int waited;
    i_req_val = 1'b0;
    waited    = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      wait_negedge();
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d results never came out after the stream ended", exp_q.size());
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // Scoreboard samples on the rising edge where inputs are settled
  always @(posedge i_clk) begin
    fp_mul_rsp_t want;
    int          issued;
    cycle <= cycle + 1;
    if (i_arst_n) begin
      if (i_req_val && o_req_rdy) begin
        want.result = ref_mod_mult(i_req.a, i_req.b);
        want.ctl    = i_req.ctl;
        exp_q.push_back(want);
        issue_q.push_back(cycle);
        in_count <= in_count + 1;
      end
      if (i_req_val && !o_req_rdy) begin
        rdy_drops++;
      end
      if (o_rsp_val && i_rsp_rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result with tag %h came out with no request outstanding", o_rsp.ctl);
        end else begin
          want         = exp_q.pop_front();
          issued       = issue_q.pop_front();
          last_latency = cycle - issued;
          checked++;
          assert (o_rsp.result == want.result) else begin
            errors++;
            $display("Error at %0t: o_rsp.result = %h, expected %h",
                     $time, o_rsp.result, want.result);
          end
          assert (o_rsp.ctl == want.ctl) else begin
            errors++;
            $display("Error at %0t: o_rsp.ctl = %h, expected %h", $time, o_rsp.ctl, want.ctl);
          end
        end
      end
    end
  end

  // Hard stop if the pipeline locks up
  initial begin
    while (cycle < MAX_CYCLES) begin
      @(posedge i_clk);
    end
    $display("Run stopped after %0d cycles with %0d results missing", cycle, exp_q.size());
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    i_arst_n     = 1'b0;
    i_req        = '0;
    i_req_val    = 1'b0;
    i_rsp_rdy    = 1'b1;
    cycle        = 0;
    in_count     = 0;
    checked      = 0;
    errors       = 0;
    test_errors  = 0;
    last_latency = 0;
    rdy_drops    = 0;
    lfsr         = 32'h7e6a_6dfd;
    rand_rdy     = 1'b0;
    next_tag     = '0;
    repeat (RST_CYCLES) @(negedge i_clk);
    i_arst_n = 1'b1;
    wait_negedge();

    // Zero, one and the top of the field
    send_req(32'd0, PM1);
    send_req(32'd1, PM1);
    send_req(PM1, PM1);
    send_req(PM1, 32'd2);
    send_req(32'd1, 32'd1);
    send_req(32'd0, 32'd0);
    drain();
    report_test("edge operands");

    for (int i = 0; i < N_RAND; i++) begin
      send_req(rand_operand(), rand_operand());
    end
    drain();
    report_test("random back to back");

    // One beat alone through an empty pipeline
    send_req(rand_operand(), rand_operand());
    drain();
    assert (last_latency == LATENCY) else begin
      errors++;
      $display("Error at %0t: o_rsp_val latency = %0d, expected %0d",
               $time, last_latency, LATENCY);
    end
    report_test("single request latency");

    rand_rdy = 1'b1;
    for (int i = 0; i < N_STALL; i++) begin
      send_req(rand_operand(), rand_operand());
    end
    drain();
    rand_rdy  = 1'b0;
    i_rsp_rdy = 1'b1;
    report_test("random back-pressure");

    // Any cycle with a waiting request and ready low counts
    rdy_drops = 0;
    for (int i = 0; i < N_SUSTAIN; i++) begin
      send_req(rand_operand(), rand_operand());
    end
    assert (rdy_drops == 0) else begin
      errors++;
      $display("Error at %0t: o_req_rdy low cycles = %0d, expected 0", $time, rdy_drops);
    end
    drain();
    report_test("sustained throughput");

    $display("Tests: 5, requests: %0d, results checked: %0d, errors: %0d",
             in_count, checked, errors);
    if (errors == 0 && checked == NUM_REQ) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+logic
logic/fp_types_pkg.sv
logic/fp_stream_pkg.sv
logic/karatsuba_ofman_mult.sv
logic/barret_mod_pipe.sv
logic/ec_fp_mult_mod.sv
testbench/tb_ec_fp_mult_mod.sv

// ==== Makefile ====
TOP := tb_ec_fp_mult_mod
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ) -f compile.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log
